// ==== src/b_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Bit-manipulation issue block, shared definitions
// Widths, major opcodes, extension configuration and lane operators
// used by the decoder, the lanes, the splitter and the writeback
////////////////////////////////////////////////////////////////////////////

package b_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////////////////////////////////////////

  // Data path width
  localparam int XLEN       = 32;
  // Instruction words per fetch bundle
  localparam int NUM_SLOTS  = 2;
  // Register address width and register count
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Major opcodes, only the two used by Zba/Zbb/Zbs
  typedef enum logic [6:0] {
    OPCODE_OP     = 7'h33,
    OPCODE_OP_IMM = 7'h13
  } opcode_e;

  // Extension configuration
  // Zbc is not built, so the last entry decodes like the second
  typedef enum logic [1:0] {
    B_NONE,
    B_ZBA_ZBB_ZBS,
    B_ZBA_ZBB_ZBC_ZBS
  } b_ext_e;

  localparam b_ext_e B_EXT_DEFAULT = B_ZBA_ZBB_ZBS;

  // Lane operations
  typedef enum logic [3:0] {
    ALU_B_SH1ADD,
    ALU_B_SH2ADD,
    ALU_B_SH3ADD,
    ALU_B_ANDN,
    ALU_B_ORN,
    ALU_B_XNOR,
    ALU_B_MIN,
    ALU_B_MAX,
    ALU_B_MINU,
    ALU_B_MAXU,
    ALU_B_BSET,
    ALU_B_BCLR,
    ALU_B_BINV,
    ALU_B_BEXT
  } alu_op_e;

endpackage

// ==== src/b_decoder.sv ====
////////////////////////////////////////////////////////////////////////////
// B-extension decoder
// Maps one instruction word to a lane operator, the destination register,
// the immediate select and the illegal flag
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module b_decoder #(
  parameter b_pkg::b_ext_e B_EXT = b_pkg::B_EXT_DEFAULT
) (
  input  logic [b_pkg::XLEN-1:0]       instr_rdata_i,
  output b_pkg::alu_op_e               alu_operator_o,
  output logic                         imm_sel_o,
  output logic [b_pkg::REG_ADDR_W-1:0] rd_o,
  output logic                         rf_we_o,
  output logic                         illegal_insn_o
);

  import b_pkg::*;

  // Sub-extension enables, B_NONE leaves all three off
  localparam bit RV32B_ZBA = (B_EXT == B_ZBA_ZBB_ZBS) || (B_EXT == B_ZBA_ZBB_ZBC_ZBS);
  localparam bit RV32B_ZBB = (B_EXT == B_ZBA_ZBB_ZBS) || (B_EXT == B_ZBA_ZBB_ZBC_ZBS);
  localparam bit RV32B_ZBS = (B_EXT == B_ZBA_ZBB_ZBS) || (B_EXT == B_ZBA_ZBB_ZBC_ZBS);

  opcode_e    opcode;
  logic [9:0] funct;
  // High when a supported and enabled encoding was found
  logic       match;

  assign opcode = opcode_e'(instr_rdata_i[6:0]);
  // funct7 on top, funct3 below
  assign funct  = {instr_rdata_i[31:25], instr_rdata_i[14:12]};
  assign rd_o   = instr_rdata_i[11:7];

  always_comb begin
    // Illegal with writes off until a match says otherwise
    alu_operator_o = ALU_B_SH1ADD;
    imm_sel_o      = 1'b0;
    match          = 1'b0;

    case (opcode)
      OPCODE_OP: begin
        case (funct)
          // Zba shift-and-add
          {7'b001_0000, 3'b010}: begin match = RV32B_ZBA; alu_operator_o = ALU_B_SH1ADD; end
          {7'b001_0000, 3'b100}: begin match = RV32B_ZBA; alu_operator_o = ALU_B_SH2ADD; end
          {7'b001_0000, 3'b110}: begin match = RV32B_ZBA; alu_operator_o = ALU_B_SH3ADD; end
          // Zbb logic with negate
          {7'b010_0000, 3'b111}: begin match = RV32B_ZBB; alu_operator_o = ALU_B_ANDN; end
          {7'b010_0000, 3'b110}: begin match = RV32B_ZBB; alu_operator_o = ALU_B_ORN; end
          {7'b010_0000, 3'b100}: begin match = RV32B_ZBB; alu_operator_o = ALU_B_XNOR; end
          // Zbb min/max, signed and unsigned
          {7'b000_0101, 3'b100}: begin match = RV32B_ZBB; alu_operator_o = ALU_B_MIN; end
          {7'b000_0101, 3'b110}: begin match = RV32B_ZBB; alu_operator_o = ALU_B_MAX; end
          {7'b000_0101, 3'b101}: begin match = RV32B_ZBB; alu_operator_o = ALU_B_MINU; end
          {7'b000_0101, 3'b111}: begin match = RV32B_ZBB; alu_operator_o = ALU_B_MAXU; end
          // Zbs register forms
          {7'b001_0100, 3'b001}: begin match = RV32B_ZBS; alu_operator_o = ALU_B_BSET; end
          {7'b010_0100, 3'b001}: begin match = RV32B_ZBS; alu_operator_o = ALU_B_BCLR; end
          {7'b011_0100, 3'b001}: begin match = RV32B_ZBS; alu_operator_o = ALU_B_BINV; end
          {7'b010_0100, 3'b101}: begin match = RV32B_ZBS; alu_operator_o = ALU_B_BEXT; end
          // Base ISA and anything unknown
          default: match = 1'b0;
        endcase
      end

      OPCODE_OP_IMM: begin
        // Zbs immediate forms, shamt sits in the rs2 field
        imm_sel_o = 1'b1;
        case (funct)
          {7'b001_0100, 3'b001}: begin match = RV32B_ZBS; alu_operator_o = ALU_B_BSET; end
          {7'b010_0100, 3'b001}: begin match = RV32B_ZBS; alu_operator_o = ALU_B_BCLR; end
          {7'b011_0100, 3'b001}: begin match = RV32B_ZBS; alu_operator_o = ALU_B_BINV; end
          {7'b010_0100, 3'b101}: begin match = RV32B_ZBS; alu_operator_o = ALU_B_BEXT; end
          default: match = 1'b0;
        endcase
      end

      // Unknown major opcode
      default: match = 1'b0;
    endcase
  end

  assign illegal_insn_o = ~match;
  assign rf_we_o        = match;

endmodule

// ==== src/b_lane.sv ====
////////////////////////////////////////////////////////////////////////////
// Issue lane
// Decodes one slot and computes its Zba/Zbb/Zbs result in the same cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module b_lane (
  input  logic                         issue_valid_i,
  input  logic [b_pkg::XLEN-1:0]       issue_instr_i,
  input  logic [b_pkg::XLEN-1:0]       rs1_data_i,
  input  logic [b_pkg::XLEN-1:0]       rs2_data_i,
  output logic                         lane_valid_o,
  output logic                         lane_we_o,
  output logic                         lane_illegal_o,
  output logic [b_pkg::REG_ADDR_W-1:0] lane_rd_o,
  output logic [b_pkg::XLEN-1:0]       lane_result_o
);

  import b_pkg::*;

  alu_op_e         alu_op;
  logic            imm_sel;
  logic            rf_we;
  logic            illegal;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [4:0]      shamt;
  // One-hot single-bit mask for the Zbs ops
  logic [XLEN-1:0] bit_mask;
  logic            lt_signed;
  logic            lt_unsigned;

  b_decoder u_decoder (
    .instr_rdata_i  (issue_instr_i),
    .alu_operator_o (alu_op),
    .imm_sel_o      (imm_sel),
    .rd_o           (lane_rd_o),
    .rf_we_o        (rf_we),
    .illegal_insn_o (illegal)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Operands
  ////////////////////////////////////////////////////////////////////////////

  assign op_a = rs1_data_i;
  // Immediate forms take shamt from instr[24:20]
  assign op_b = imm_sel ? {{(XLEN-5){1'b0}}, issue_instr_i[24:20]} : rs2_data_i;

  // Only the low 5 bits select a bit position
  assign shamt    = op_b[4:0];
  assign bit_mask = {{(XLEN-1){1'b0}}, 1'b1} << shamt;

  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;

  ////////////////////////////////////////////////////////////////////////////
  // Result
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_op)
      // rs2 + (rs1 << n)
      ALU_B_SH1ADD: lane_result_o = op_b + (op_a << 1);
      ALU_B_SH2ADD: lane_result_o = op_b + (op_a << 2);
      ALU_B_SH3ADD: lane_result_o = op_b + (op_a << 3);
      ALU_B_ANDN:   lane_result_o = op_a & ~op_b;
      ALU_B_ORN:    lane_result_o = op_a | ~op_b;
      ALU_B_XNOR:   lane_result_o = ~(op_a ^ op_b);
      ALU_B_MIN:    lane_result_o = lt_signed   ? op_a : op_b;
      ALU_B_MAX:    lane_result_o = lt_signed   ? op_b : op_a;
      ALU_B_MINU:   lane_result_o = lt_unsigned ? op_a : op_b;
      ALU_B_MAXU:   lane_result_o = lt_unsigned ? op_b : op_a;
      ALU_B_BSET:   lane_result_o = op_a | bit_mask;
      ALU_B_BCLR:   lane_result_o = op_a & ~bit_mask;
      ALU_B_BINV:   lane_result_o = op_a ^ bit_mask;
      // Single extracted bit in bit 0
      ALU_B_BEXT:   lane_result_o = {{(XLEN-1){1'b0}}, op_a[shamt]};
      default:      lane_result_o = '0;
    endcase
  end

  // Status only counts while the slot is really issued
  assign lane_valid_o   = issue_valid_i & ~illegal;
  assign lane_we_o      = issue_valid_i & rf_we;
  assign lane_illegal_o = issue_valid_i & illegal;

endmodule

// ==== src/b_issue_split.sv ====
////////////////////////////////////////////////////////////////////////////
// Issue splitter
// Registers the fetch bundle and its source operands, taking operands
// from the bundle in flight ahead of the register file
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module b_issue_split (
  input  logic                                                   clk,
  input  logic                                                   arst_n_i,
  input  logic                                                   bundle_valid_i,
  input  logic [b_pkg::NUM_SLOTS-1:0][b_pkg::XLEN-1:0]           bundle_instr_i,
  input  logic [b_pkg::NUM_SLOTS-1:0][1:0][b_pkg::XLEN-1:0]      rf_rdata_i,
  input  logic [b_pkg::NUM_SLOTS-1:0]                            lane_we_i,
  input  logic [b_pkg::NUM_SLOTS-1:0][b_pkg::REG_ADDR_W-1:0]     lane_rd_i,
  input  logic [b_pkg::NUM_SLOTS-1:0][b_pkg::XLEN-1:0]           lane_result_i,
  output logic [b_pkg::NUM_SLOTS-1:0][1:0][b_pkg::REG_ADDR_W-1:0] rf_raddr_o,
  output logic [b_pkg::NUM_SLOTS-1:0]                            issue_valid_o,
  output logic [b_pkg::NUM_SLOTS-1:0][b_pkg::XLEN-1:0]           issue_instr_o,
  output logic [b_pkg::NUM_SLOTS-1:0][b_pkg::XLEN-1:0]           issue_rs1_data_o,
  output logic [b_pkg::NUM_SLOTS-1:0][b_pkg::XLEN-1:0]           issue_rs2_data_o
);

  import b_pkg::*;

  // Operand per slot and source, index 0 is rs1
  logic [NUM_SLOTS-1:0][1:0][XLEN-1:0] operand;

  ////////////////////////////////////////////////////////////////////////////
  // Read addresses and forwarding
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int s = 0; s < NUM_SLOTS; s++) begin
      rf_raddr_o[s][0] = bundle_instr_i[s][19:15];
      rf_raddr_o[s][1] = bundle_instr_i[s][24:20];
    end
  end

  // Lane results of the registered bundle are not in the register file yet
  // Higher slots are checked later so slot 1 beats slot 0
  always_comb begin
    for (int s = 0; s < NUM_SLOTS; s++) begin
      for (int j = 0; j < 2; j++) begin
        operand[s][j] = rf_rdata_i[s][j];
        for (int k = 0; k < NUM_SLOTS; k++) begin
          // x0 never forwards
          if (lane_we_i[k] && (lane_rd_i[k] == rf_raddr_o[s][j]) &&
              (rf_raddr_o[s][j] != '0)) begin
            operand[s][j] = lane_result_i[k];
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Issue registers
  ////////////////////////////////////////////////////////////////////////////

  // Both slots share the bundle strobe
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      issue_valid_o <= '0;
    end else begin
      issue_valid_o <= {NUM_SLOTS{bundle_valid_i}};
    end
  end

  // Payload, loaded only with a bundle
  always_ff @(posedge clk) begin
    if (bundle_valid_i) begin
      for (int s = 0; s < NUM_SLOTS; s++) begin
        issue_instr_o[s]    <= bundle_instr_i[s];
        issue_rs1_data_o[s] <= operand[s][0];
        issue_rs2_data_o[s] <= operand[s][1];
      end
    end
  end

endmodule

// ==== src/b_writeback.sv ====
////////////////////////////////////////////////////////////////////////////
// Writeback
// Register file with x0 tied to zero, commits both lanes in slot order
// and reports the lane results at the block outputs
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module b_writeback (
  input  logic                                                   clk,
  input  logic                                                   arst_n_i,
  input  logic [b_pkg::NUM_SLOTS-1:0][1:0][b_pkg::REG_ADDR_W-1:0] rf_raddr_i,
  input  logic [b_pkg::NUM_SLOTS-1:0]                            lane_valid_i,
  input  logic [b_pkg::NUM_SLOTS-1:0]                            lane_we_i,
  input  logic [b_pkg::NUM_SLOTS-1:0]                            lane_illegal_i,
  input  logic [b_pkg::NUM_SLOTS-1:0][b_pkg::REG_ADDR_W-1:0]     lane_rd_i,
  input  logic [b_pkg::NUM_SLOTS-1:0][b_pkg::XLEN-1:0]           lane_result_i,
  output logic [b_pkg::NUM_SLOTS-1:0][1:0][b_pkg::XLEN-1:0]      rf_rdata_o,
  output logic [b_pkg::NUM_SLOTS-1:0]                            wb_valid_o,
  output logic [b_pkg::NUM_SLOTS-1:0]                            wb_illegal_o,
  output logic [b_pkg::NUM_SLOTS-1:0][b_pkg::REG_ADDR_W-1:0]     wb_rd_o,
  output logic [b_pkg::NUM_SLOTS-1:0][b_pkg::XLEN-1:0]           wb_data_o
);

  import b_pkg::*;

  logic [NUM_REGS-1:0][XLEN-1:0] regs;

  ////////////////////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////////////////////

  // Slot loop runs upward, the last nonblocking write to an rd wins
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      regs <= '0;
    end else begin
      for (int s = 0; s < NUM_SLOTS; s++) begin
        // Writes to x0 are dropped
        if (lane_we_i[s] && (lane_rd_i[s] != '0)) begin
          regs[lane_rd_i[s]] <= lane_result_i[s];
        end
      end
    end
  end

  // Two asynchronous read ports per slot
  always_comb begin
    for (int s = 0; s < NUM_SLOTS; s++) begin
      for (int j = 0; j < 2; j++) begin
        rf_rdata_o[s][j] = (rf_raddr_i[s][j] == '0) ? '0 : regs[rf_raddr_i[s][j]];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Commit report
  ////////////////////////////////////////////////////////////////////////////

  assign wb_valid_o   = lane_valid_i;
  assign wb_illegal_o = lane_illegal_i;
  assign wb_rd_o      = lane_rd_i;

  // Data reads zero unless the slot committed
  always_comb begin
    for (int s = 0; s < NUM_SLOTS; s++) begin
      wb_data_o[s] = lane_valid_i[s] ? lane_result_i[s] : '0;
    end
  end

endmodule

// ==== src/b_bitmanip_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Two-slot bit-manipulation issue block, top level
// Splitter, one lane per slot and the writeback with its register file
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module b_bitmanip_top (
  input  logic                                               clk,
  input  logic                                               arst_n_i,
  input  logic                                               bundle_valid_i,
  input  logic [b_pkg::NUM_SLOTS-1:0][b_pkg::XLEN-1:0]       bundle_instr_i,
  output logic [b_pkg::NUM_SLOTS-1:0]                        wb_valid_o,
  output logic [b_pkg::NUM_SLOTS-1:0]                        wb_illegal_o,
  output logic [b_pkg::NUM_SLOTS-1:0][b_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [b_pkg::NUM_SLOTS-1:0][b_pkg::XLEN-1:0]       wb_data_o
);

  import b_pkg::*;

  // Register file read path
  logic [NUM_SLOTS-1:0][1:0][REG_ADDR_W-1:0] rd_addr;
  logic [NUM_SLOTS-1:0][1:0][XLEN-1:0]       rd_data;

  // Splitter to lanes
  logic [NUM_SLOTS-1:0]            issue_valid;
  logic [NUM_SLOTS-1:0][XLEN-1:0]  issue_instr;
  logic [NUM_SLOTS-1:0][XLEN-1:0]  issue_rs1_data;
  logic [NUM_SLOTS-1:0][XLEN-1:0]  issue_rs2_data;

  // Lanes to writeback and forwarding
  logic [NUM_SLOTS-1:0]                  lane_valid;
  logic [NUM_SLOTS-1:0]                  lane_we;
  logic [NUM_SLOTS-1:0]                  lane_illegal;
  logic [NUM_SLOTS-1:0][REG_ADDR_W-1:0]  lane_rd;
  logic [NUM_SLOTS-1:0][XLEN-1:0]        lane_result;

  b_issue_split u_issue_split (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .bundle_valid_i   (bundle_valid_i),
    .bundle_instr_i   (bundle_instr_i),
    .rf_rdata_i       (rd_data),
    .lane_we_i        (lane_we),
    .lane_rd_i        (lane_rd),
    .lane_result_i    (lane_result),
    .rf_raddr_o       (rd_addr),
    .issue_valid_o    (issue_valid),
    .issue_instr_o    (issue_instr),
    .issue_rs1_data_o (issue_rs1_data),
    .issue_rs2_data_o (issue_rs2_data)
  );

  // One lane per slot
  for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_lane
    b_lane u_lane (
      .issue_valid_i  (issue_valid[s]),
      .issue_instr_i  (issue_instr[s]),
      .rs1_data_i     (issue_rs1_data[s]),
      .rs2_data_i     (issue_rs2_data[s]),
      .lane_valid_o   (lane_valid[s]),
      .lane_we_o      (lane_we[s]),
      .lane_illegal_o (lane_illegal[s]),
      .lane_rd_o      (lane_rd[s]),
      .lane_result_o  (lane_result[s])
    );
  end

  b_writeback u_writeback (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .rf_raddr_i     (rd_addr),
    .lane_valid_i   (lane_valid),
    .lane_we_i      (lane_we),
    .lane_illegal_i (lane_illegal),
    .lane_rd_i      (lane_rd),
    .lane_result_i  (lane_result),
    .rf_rdata_o     (rd_data),
    .wb_valid_o     (wb_valid_o),
    .wb_illegal_o   (wb_illegal_o),
    .wb_rd_o        (wb_rd_o),
    .wb_data_o      (wb_data_o)
  );

endmodule

// ==== bench/tb_b_bitmanip.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the two-slot bit-manipulation issue block
// Replays fetch bundles from a stimulus file and checks the writeback
// outputs of each bundle one cycle after it is driven
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_b_bitmanip;

  import b_pkg::*;

  // Half of the 20 ns clock period
  localparam int HALF_PERIOD = 10;

  logic                                 clk;
  logic                                 arst_n_i;
  logic                                 bundle_valid_i;
  logic [NUM_SLOTS-1:0][XLEN-1:0]       bundle_instr_i;
  logic [NUM_SLOTS-1:0]                 wb_valid_o;
  logic [NUM_SLOTS-1:0]                 wb_illegal_o;
  logic [NUM_SLOTS-1:0][REG_ADDR_W-1:0] wb_rd_o;
  logic [NUM_SLOTS-1:0][XLEN-1:0]       wb_data_o;

  // One entry per data line of the stimulus file
  int          vec_id[$];
  logic [31:0] vec_valid[$];
  logic [31:0] vec_instr0[$];
  logic [31:0] vec_instr1[$];
  // Expected writeback, slot 0 then slot 1
  logic [31:0] exp_v0[$];
  logic [31:0] exp_il0[$];
  logic [31:0] exp_rd0[$];
  logic [31:0] exp_data0[$];
  logic [31:0] exp_v1[$];
  logic [31:0] exp_il1[$];
  logic [31:0] exp_rd1[$];
  logic [31:0] exp_data1[$];

  int errors;
  int test_errors;
  int test_bundles;
  int test_count;
  bit loaded;

  b_bitmanip_top UUT (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .bundle_valid_i (bundle_valid_i),
    .bundle_instr_i (bundle_instr_i),
    .wb_valid_o     (wb_valid_o),
    .wb_illegal_o   (wb_illegal_o),
    .wb_rd_o        (wb_rd_o),
    .wb_data_o      (wb_data_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus loading
  ////////////////////////////////////////////////////////////////////////////

  // Lines that do not scan as twelve fields are comments or blank
  task automatic load_vectors();
    int          fd;
    int          code;
    int          fields;
    int          id;
    string       line;
    logic [31:0] f [11];
    fd = $fopen("bench/b_stimulus.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code != 0) begin
          fields = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h", id,
                           f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                           f[9], f[10]);
          if (fields == 12) begin
            vec_id.push_back(id);
            vec_valid.push_back(f[0]);
            vec_instr0.push_back(f[1]);
            vec_instr1.push_back(f[2]);
            exp_v0.push_back(f[3]);
            exp_il0.push_back(f[4]);
            exp_rd0.push_back(f[5]);
            exp_data0.push_back(f[6]);
            exp_v1.push_back(f[7]);
            exp_il1.push_back(f[8]);
            exp_rd1.push_back(f[9]);
            exp_data1.push_back(f[10]);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_slot(input int slot, input logic got_valid, input logic got_illegal,
                            input logic [REG_ADDR_W-1:0] got_rd,
                            input logic [XLEN-1:0] got_data, input logic want_valid,
                            input logic want_illegal, input logic [REG_ADDR_W-1:0] want_rd,
                            input logic [XLEN-1:0] want_data);
    assert (got_valid === want_valid) else begin
      $display("Error wb_valid_o[%0d] expected %h got %h", slot, want_valid, got_valid);
      test_errors++;
    end
    assert (got_illegal === want_illegal) else begin
      $display("Error wb_illegal_o[%0d] expected %h got %h", slot, want_illegal, got_illegal);
      test_errors++;
    end
    // rd is only meaningful for an issued slot
    if (want_valid || want_illegal) begin
      assert (got_rd === want_rd) else begin
        $display("Error wb_rd_o[%0d] expected %h got %h", slot, want_rd, got_rd);
        test_errors++;
      end
    end
    assert (got_data === want_data) else begin
      $display("Error wb_data_o[%0d] expected %h got %h", slot, want_data, got_data);
      test_errors++;
    end
  endtask

  // Compares both slots, closes the test on its last bundle
  task automatic check_bundle(input int i);
    check_slot(0, wb_valid_o[0], wb_illegal_o[0], wb_rd_o[0], wb_data_o[0],
               exp_v0[i][0], exp_il0[i][0], exp_rd0[i][4:0], exp_data0[i]);
    check_slot(1, wb_valid_o[1], wb_illegal_o[1], wb_rd_o[1], wb_data_o[1],
               exp_v1[i][0], exp_il1[i][0], exp_rd1[i][4:0], exp_data1[i]);
    test_bundles++;
    if ((i == vec_id.size() - 1) || (vec_id[i + 1] != vec_id[i])) begin
      $display("test %0d: %0d bundles, %0d errors", vec_id[i], test_bundles, test_errors);
      errors += test_errors;
      test_errors  = 0;
      test_bundles = 0;
      test_count++;
    end
  endtask

  task automatic apply_reset();
    arst_n_i = 1'b0;
    repeat (4) @(negedge clk);
    arst_n_i = 1'b1;
    // Nothing issued yet
    assert (wb_valid_o === '0) else begin
      $display("Error wb_valid_o expected 0 got %h after reset", wb_valid_o);
      errors++;
    end
    assert (wb_illegal_o === '0) else begin
      $display("Error wb_illegal_o expected 0 got %h after reset", wb_illegal_o);
      errors++;
    end
  endtask

  // Drive on each falling edge, check the bundle of the previous one
  task automatic run_vectors();
    for (int i = 0; i <= vec_id.size(); i++) begin
      @(negedge clk);
      if (i > 0) begin
        check_bundle(i - 1);
      end
      if (i < vec_id.size()) begin
        bundle_valid_i    = vec_valid[i][0];
        bundle_instr_i[0] = vec_instr0[i];
        bundle_instr_i[1] = vec_instr1[i];
      end else begin
        bundle_valid_i = 1'b0;
        bundle_instr_i = '0;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Processes
  ////////////////////////////////////////////////////////////////////////////

  initial begin : clock_gen
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin : main
    arst_n_i       = 1'b0;
    bundle_valid_i = 1'b0;
    bundle_instr_i = '0;
    errors         = 0;
    test_errors    = 0;
    test_bundles   = 0;
    test_count     = 0;
    load_vectors();
    loaded = 1'b1;
    if (vec_id.size() > 0) begin
      apply_reset();
      run_vectors();
    end else begin
      $display("No vectors could be read from bench/b_stimulus.txt");
      errors++;
    end
    $display("%0d tests, %0d bundles, %0d errors", test_count, vec_id.size(), errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Limit scales with the number of bundles
  initial begin : watchdog
    int limit_ns;
    wait (loaded);
    limit_ns = (vec_id.size() + 10) * 40;
    #(limit_ns);
    $display("Simulation timed out after %0d ns before all bundles were checked", limit_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== bench/b_stimulus.txt ====
# Columns: test id, bundle valid, instr slot 0, instr slot 1, then per slot
# expected wb valid, wb illegal, wb rd, wb data (all but the id in hex)
# Test 1: registers read zero after reset, x0 write dropped, x0 reads zero
1 1 403140b3 2062a233 1 0 01 ffffffff 1 0 04 00000000
1 1 28501013 28901393 1 0 00 00000020 1 0 07 00000200
1 1 20706133 69f01193 1 0 02 00000200 1 0 03 80000000
1 0 00000000 00000000 0 0 00 00000000 0 0 00 00000000
# Test 2: Zba sh1add sh2add sh3add on operands built with bseti
2 1 28001293 28c01313 1 0 05 00000001 1 0 06 00001000
2 1 28229293 28331313 1 0 05 00000005 1 0 06 00001008
2 1 28429293 29f31313 1 0 05 00000015 1 0 06 80001008
2 1 2062a433 2062c4b3 1 0 08 80001032 1 0 09 8000105c
2 1 20536533 2062e5b3 1 0 0a 00008055 1 0 0b 800010b0
# Test 3: Zbb andn orn xnor, signed and unsigned min max with sign bit set
3 1 40557633 40a2e6b3 1 0 0c 00008040 1 0 0d ffff7fbf
3 1 40a34733 0a51c7b3 1 0 0e 7fff6fa2 1 0 0f 80000000
3 1 0a51e833 0a51d8b3 1 0 10 00000015 1 0 11 00000015
3 1 0a51f933 0a3369b3 1 0 12 80000000 1 0 13 80001008
# Test 4: Zbs bset bclr binv bext, register and immediate forms
4 1 28651a33 48609ab3 1 0 14 00008155 1 0 15 fffffeff
4 1 68551b33 4811dbb3 1 0 16 00208055 1 0 17 00000001
4 1 49f31c13 68051c93 1 0 18 00001008 1 0 19 00008054
4 1 48c35d13 48155d93 1 0 1a 00000001 1 0 1b 00000000
# Test 5: forwarding, same-bundle reads see old values, slot 1 wins on same rd
5 1 28701e13 21ce2eb3 1 0 1c 00000080 1 0 1d 00000000
5 1 21ce2f33 28301f13 1 0 1e 00000180 1 0 1e 00000008
5 1 680f1f93 21e04eb3 1 0 1f 00000009 1 0 1d 00000008
5 0 00000000 00000000 0 0 00 00000000 0 0 00 00000000
5 1 21e02233 0bdff3b3 1 0 04 00000008 1 0 07 00000009
# Test 6: base add, rol, load opcode and addi are illegal and leave rd alone
6 1 00628633 606296b3 0 1 0c 00000000 0 1 0d 00000000
6 1 00032703 00128793 0 1 0e 00000000 0 1 0f 00000000
6 1 20e02833 20f028b3 1 0 10 7fff6fa2 1 0 11 80000000
6 1 20c02933 20d029b3 1 0 12 00008040 1 0 13 ffff7fbf

// ==== build.f ====
src/b_pkg.sv
src/b_decoder.sv
src/b_lane.sv
src/b_issue_split.sv
src/b_writeback.sv
src/b_bitmanip_top.sv
bench/tb_b_bitmanip.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the bit-manipulation testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f build.f --top-module tb_b_bitmanip -o tb_b_bitmanip

# Output stays in a variable and is searched for the pass line
sim_out=$(./obj_dir/tb_b_bitmanip)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1
